// File: common/br_defs.svh
`ifndef BR_DEFS_SVH
`define BR_DEFS_SVH

// datapath
`define BR_XLEN         32

// cluster shape
`define BR_NUM_STATIONS 3
`define BR_STATION_IDX  2
`define BR_RS_DEPTH     4
`define BR_RS_IDX       2

// physical register space and rob ids
`define BR_PHYS_REGS    64
`define BR_PHYS_IDX     6
`define BR_ROB_IDX      5

`endif

// File: common/br_pkg.sv
`include "br_defs.svh"

package br_pkg;

    ////////////////////////////////////////
    // branch opcodes
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        BLT  = 3'd2,
        BGE  = 3'd3,
        BLTU = 3'd4,
        BGEU = 3'd5,
        JAL  = 3'd6,
        JALR = 3'd7
    } br_op_e;

    ////////////////////////////////////////
    // pipeline payloads
    ////////////////////////////////////////

    // renamed micro-op as handed over by dispatch
    typedef struct packed {
        logic [`BR_ROB_IDX-1:0]  rob_id;
        br_op_e                  op;
        logic [`BR_PHYS_IDX-1:0] rd_phy;
        logic [`BR_PHYS_IDX-1:0] rs1_phy;
        logic                    rs1_ready;
        logic [`BR_PHYS_IDX-1:0] rs2_phy;
        logic                    rs2_ready;
        logic [`BR_XLEN-1:0]     pc;
        logic [`BR_XLEN-1:0]     imm;
        logic                    predict_taken;
        logic [`BR_XLEN-1:0]     predict_target;
    } br_uop_t;

    // operation leaving a station, operands resolved
    typedef struct packed {
        logic [`BR_ROB_IDX-1:0]  rob_id;
        br_op_e                  op;
        logic [`BR_PHYS_IDX-1:0] rd_phy;
        logic [`BR_XLEN-1:0]     pc;
        logic [`BR_XLEN-1:0]     imm;
        logic                    predict_taken;
        logic [`BR_XLEN-1:0]     predict_target;
        logic [`BR_XLEN-1:0]     rs1_value;
        logic [`BR_XLEN-1:0]     rs2_value;
    } br_issue_t;

    typedef struct packed {
        logic [`BR_ROB_IDX-1:0]  rob_id;
        logic [`BR_PHYS_IDX-1:0] rd_phy;
        logic [`BR_XLEN-1:0]     link_value;
        logic                    taken;
        logic [`BR_XLEN-1:0]     target;
        logic                    mispredict;
    } br_result_t;

    // one broadcast write, cdb or external write-back
    typedef struct packed {
        logic                    valid;
        logic [`BR_PHYS_IDX-1:0] rd_phy;
        logic [`BR_XLEN-1:0]     value;
    } wb_t;

endpackage

// File: logic/br_unit.sv
`timescale 1ns/100ps
`include "br_defs.svh"

module br_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  br_pkg::br_issue_t  issue,
    output logic               unit_ready,
    output logic               req,
    input  logic               ack,
    output br_pkg::br_result_t result
);
    logic                busy;
    logic                taken;
    logic [`BR_XLEN-1:0] jalr_sum;
    logic [`BR_XLEN-1:0] target;
    logic                mispredict;

    ////////////////////////////////////////
    // resolution
    ////////////////////////////////////////

    always_comb begin
        case (issue.op)
            br_pkg::BEQ:  taken = issue.rs1_value == issue.rs2_value;
            br_pkg::BNE:  taken = issue.rs1_value != issue.rs2_value;
            br_pkg::BLT:  taken = $signed(issue.rs1_value) <  $signed(issue.rs2_value);
            br_pkg::BGE:  taken = $signed(issue.rs1_value) >= $signed(issue.rs2_value);
            br_pkg::BLTU: taken = issue.rs1_value <  issue.rs2_value;
            br_pkg::BGEU: taken = issue.rs1_value >= issue.rs2_value;
            // jal and jalr
            default:      taken = 1'b1;
        endcase
    end

    assign jalr_sum   = issue.rs1_value + issue.imm;
    assign target     = (issue.op == br_pkg::JALR) ? {jalr_sum[`BR_XLEN-1:1], 1'b0}
                                                   : issue.pc + issue.imm;
    assign mispredict = (taken != issue.predict_taken) ||
                        (taken && (target != issue.predict_target));

    always_ff @(posedge clk) begin
        if (issue_valid && unit_ready) begin
            result.rob_id     <= issue.rob_id;
            result.rd_phy     <= issue.rd_phy;
            result.link_value <= issue.pc + `BR_XLEN'(4);
            result.taken      <= taken;
            result.target     <= target;
            result.mispredict <= mispredict;
        end
    end

    ////////////////////////////////////////
    // four-phase req side
    ////////////////////////////////////////

    // busy until ack has dropped again
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            req  <= 1'b0;
        end else if (issue_valid && unit_ready) begin
            busy <= 1'b1;
            req  <= 1'b1;
        end else if (req && ack) begin
            req <= 1'b0;
        end else if (busy && !req && !ack) begin
            busy <= 1'b0;
        end
    end

    assign unit_ready = !busy;

endmodule

// File: rs/rs_station.sv
`timescale 1ns/100ps
`include "br_defs.svh"

module rs_station (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push,
    input  br_pkg::br_uop_t         push_uop,
    output logic                    slot_free,
    input  br_pkg::wb_t             cdb,
    input  br_pkg::wb_t             ext_wb,
    output logic [`BR_PHYS_IDX-1:0] rs1_tag,
    output logic [`BR_PHYS_IDX-1:0] rs2_tag,
    input  logic [`BR_XLEN-1:0]     rs1_value,
    input  logic [`BR_XLEN-1:0]     rs2_value,
    output logic                    req,
    input  logic                    ack,
    output br_pkg::br_result_t      result
);
    br_pkg::br_uop_t         entry [`BR_RS_DEPTH];
    logic [`BR_RS_DEPTH-1:0] occupied;

    logic [`BR_RS_IDX-1:0]   push_idx;
    br_pkg::br_uop_t         push_woken;
    logic                    issue_valid;
    logic [`BR_RS_IDX-1:0]   issue_idx;
    logic                    unit_ready;
    br_pkg::br_issue_t       issue;

    // tag 0 never matches, its writes are dropped
    function automatic logic bus_hit(input br_pkg::wb_t wb, input logic [`BR_PHYS_IDX-1:0] tag);
        return wb.valid && (wb.rd_phy != '0) && (wb.rd_phy == tag);
    endfunction

    function automatic logic operand_ok(input logic ready, input logic [`BR_PHYS_IDX-1:0] tag,
                                        input br_pkg::wb_t wb_a, input br_pkg::wb_t wb_b);
        return ready || (tag == '0) || bus_hit(wb_a, tag) || bus_hit(wb_b, tag);
    endfunction

    ////////////////////////////////////////
    // entry allocation
    ////////////////////////////////////////

    assign slot_free = ~&occupied;

    // lowest free slot wins
    always_comb begin
        push_idx = '0;
        for (int i = `BR_RS_DEPTH - 1; i >= 0; i--) begin
            if (!occupied[i]) begin
                push_idx = (`BR_RS_IDX)'(i);
            end
        end
    end

    // a broadcast in the push cycle must not be missed
    always_comb begin
        push_woken = push_uop;
        if (bus_hit(cdb, push_uop.rs1_phy) || bus_hit(ext_wb, push_uop.rs1_phy)) begin
            push_woken.rs1_ready = 1'b1;
        end
        if (bus_hit(cdb, push_uop.rs2_phy) || bus_hit(ext_wb, push_uop.rs2_phy)) begin
            push_woken.rs2_ready = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= '0;
        end else begin
            if (issue_valid && unit_ready) begin
                occupied[issue_idx] <= 1'b0;
            end
            if (push) begin
                occupied[push_idx] <= 1'b1;
            end
        end
    end

    // snoop both buses, then let a push overwrite its slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < `BR_RS_DEPTH; i++) begin
            if (bus_hit(cdb, entry[i].rs1_phy) || bus_hit(ext_wb, entry[i].rs1_phy)) begin
                entry[i].rs1_ready <= 1'b1;
            end
            if (bus_hit(cdb, entry[i].rs2_phy) || bus_hit(ext_wb, entry[i].rs2_phy)) begin
                entry[i].rs2_ready <= 1'b1;
            end
        end
        if (push) begin
            entry[push_idx] <= push_woken;
        end
    end

    ////////////////////////////////////////
    // issue select
    ////////////////////////////////////////

    always_comb begin
        issue_valid = 1'b0;
        issue_idx   = '0;
        for (int i = `BR_RS_DEPTH - 1; i >= 0; i--) begin
            if (occupied[i] &&
                operand_ok(entry[i].rs1_ready, entry[i].rs1_phy, cdb, ext_wb) &&
                operand_ok(entry[i].rs2_ready, entry[i].rs2_phy, cdb, ext_wb)) begin
                issue_valid = 1'b1;
                issue_idx   = (`BR_RS_IDX)'(i);
            end
        end
    end

    assign rs1_tag = entry[issue_idx].rs1_phy;
    assign rs2_tag = entry[issue_idx].rs2_phy;

    // bus value first, register file otherwise
    always_comb begin
        issue.rob_id         = entry[issue_idx].rob_id;
        issue.op             = entry[issue_idx].op;
        issue.rd_phy         = entry[issue_idx].rd_phy;
        issue.pc             = entry[issue_idx].pc;
        issue.imm            = entry[issue_idx].imm;
        issue.predict_taken  = entry[issue_idx].predict_taken;
        issue.predict_target = entry[issue_idx].predict_target;
        issue.rs1_value      = bus_hit(cdb, rs1_tag)    ? cdb.value    :
                               bus_hit(ext_wb, rs1_tag) ? ext_wb.value : rs1_value;
        issue.rs2_value      = bus_hit(cdb, rs2_tag)    ? cdb.value    :
                               bus_hit(ext_wb, rs2_tag) ? ext_wb.value : rs2_value;
    end

    br_unit u_br_unit (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .unit_ready  (unit_ready),
        .req         (req),
        .ack         (ack),
        .result      (result)
    );

endmodule

// File: logic/br_dispatch.sv
`timescale 1ns/100ps
`include "br_defs.svh"

module br_dispatch (
    input  logic                        disp_valid,
    input  br_pkg::br_uop_t             disp_uop,
    output logic                        disp_ready,
    input  logic [`BR_NUM_STATIONS-1:0] slot_free,
    output logic [`BR_NUM_STATIONS-1:0] push,
    output br_pkg::br_uop_t             push_uop
);
    logic found;

    ////////////////////////////////////////
    // station steering
    ////////////////////////////////////////

    // any station with room can take the micro-op
    assign disp_ready = |slot_free;

    // every station sees the same payload, only push differs
    assign push_uop = disp_uop;

    // lowest-numbered station with a free entry
    always_comb begin
        push  = '0;
        found = 1'b0;
        for (int s = 0; s < `BR_NUM_STATIONS; s++) begin
            if (slot_free[s] && !found) begin
                push[s] = disp_valid;
                found   = 1'b1;
            end
        end
    end

endmodule

// File: logic/cdb_arbiter.sv
`timescale 1ns/100ps
`include "br_defs.svh"

module cdb_arbiter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`BR_NUM_STATIONS-1:0] req,
    output logic [`BR_NUM_STATIONS-1:0] ack,
    input  br_pkg::br_result_t          result [`BR_NUM_STATIONS],
    output br_pkg::wb_t                 cdb,
    output logic                        cdb_valid,
    output br_pkg::br_result_t          cdb_result
);
    logic [`BR_STATION_IDX-1:0]  rr_ptr;
    logic [`BR_STATION_IDX-1:0]  grant_idx;
    logic                        grant_valid;
    logic [`BR_NUM_STATIONS-1:0] pending;

    // ack still high means that handshake is not finished
    assign pending = req & ~ack;

    ////////////////////////////////////////
    // round-robin pick
    ////////////////////////////////////////

    // nearest pending station at or after the pointer
    always_comb begin
        int slot;
        grant_valid = 1'b0;
        grant_idx   = rr_ptr;
        for (int k = `BR_NUM_STATIONS - 1; k >= 0; k--) begin
            slot = (int'(rr_ptr) + k) % `BR_NUM_STATIONS;
            if (pending[slot]) begin
                grant_valid = 1'b1;
                grant_idx   = (`BR_STATION_IDX)'(slot);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr    <= '0;
            ack       <= '0;
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= grant_valid;
            for (int s = 0; s < `BR_NUM_STATIONS; s++) begin
                if (ack[s] && !req[s]) begin
                    ack[s] <= 1'b0;
                end
            end
            if (grant_valid) begin
                ack[grant_idx] <= 1'b1;
                rr_ptr <= (grant_idx == (`BR_STATION_IDX)'(`BR_NUM_STATIONS - 1)) ? '0
                                                                                 : grant_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_valid) begin
            cdb_result <= result[grant_idx];
        end
    end

    // wakeup and register write carry the link value
    assign cdb.valid  = cdb_valid;
    assign cdb.rd_phy = cdb_result.rd_phy;
    assign cdb.value  = cdb_result.link_value;

endmodule

// File: logic/phys_regfile.sv
`timescale 1ns/100ps
`include "br_defs.svh"

module phys_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  br_pkg::wb_t             cdb,
    input  br_pkg::wb_t             ext_wb,
    input  logic [`BR_PHYS_IDX-1:0] rd1_tag   [`BR_NUM_STATIONS],
    input  logic [`BR_PHYS_IDX-1:0] rd2_tag   [`BR_NUM_STATIONS],
    output logic [`BR_XLEN-1:0]     rd1_value [`BR_NUM_STATIONS],
    output logic [`BR_XLEN-1:0]     rd2_value [`BR_NUM_STATIONS]
);
    logic [`BR_XLEN-1:0] regs [`BR_PHYS_REGS];

    ////////////////////////////////////////
    // write ports
    ////////////////////////////////////////

    // both buses never hit the same tag in one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `BR_PHYS_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (cdb.valid && (cdb.rd_phy != '0)) begin
                regs[cdb.rd_phy] <= cdb.value;
            end
            if (ext_wb.valid && (ext_wb.rd_phy != '0)) begin
                regs[ext_wb.rd_phy] <= ext_wb.value;
            end
        end
    end

    ////////////////////////////////////////
    // read pairs, one per station
    ////////////////////////////////////////

    // old value on a same-cycle write, x0 reads zero
    always_comb begin
        for (int s = 0; s < `BR_NUM_STATIONS; s++) begin
            rd1_value[s] = (rd1_tag[s] == '0) ? '0 : regs[rd1_tag[s]];
            rd2_value[s] = (rd2_tag[s] == '0) ? '0 : regs[rd2_tag[s]];
        end
    end

endmodule

// File: logic/br_cluster.sv
`timescale 1ns/100ps
`include "br_defs.svh"

module br_cluster (
    input  logic               clk,
    input  logic               rst,
    input  logic               disp_valid,
    input  br_pkg::br_uop_t    disp_uop,
    output logic               disp_ready,
    input  br_pkg::wb_t        ext_wb,
    output logic               cdb_valid,
    output br_pkg::br_result_t cdb_result
);
    logic [`BR_NUM_STATIONS-1:0] slot_free;
    logic [`BR_NUM_STATIONS-1:0] push;
    br_pkg::br_uop_t             push_uop;

    logic [`BR_PHYS_IDX-1:0]     rs1_tag   [`BR_NUM_STATIONS];
    logic [`BR_PHYS_IDX-1:0]     rs2_tag   [`BR_NUM_STATIONS];
    logic [`BR_XLEN-1:0]         rs1_value [`BR_NUM_STATIONS];
    logic [`BR_XLEN-1:0]         rs2_value [`BR_NUM_STATIONS];

    logic [`BR_NUM_STATIONS-1:0] req;
    logic [`BR_NUM_STATIONS-1:0] ack;
    br_pkg::br_result_t          result [`BR_NUM_STATIONS];
    br_pkg::wb_t                 cdb;

    br_dispatch u_dispatch (
        .disp_valid (disp_valid),
        .disp_uop   (disp_uop),
        .disp_ready (disp_ready),
        .slot_free  (slot_free),
        .push       (push),
        .push_uop   (push_uop)
    );

    ////////////////////////////////////////
    // stations, each with its branch unit
    ////////////////////////////////////////

    for (genvar s = 0; s < `BR_NUM_STATIONS; s++) begin : g_station
        rs_station u_station (
            .clk       (clk),
            .rst       (rst),
            .push      (push[s]),
            .push_uop  (push_uop),
            .slot_free (slot_free[s]),
            .cdb       (cdb),
            .ext_wb    (ext_wb),
            .rs1_tag   (rs1_tag[s]),
            .rs2_tag   (rs2_tag[s]),
            .rs1_value (rs1_value[s]),
            .rs2_value (rs2_value[s]),
            .req       (req[s]),
            .ack       (ack[s]),
            .result    (result[s])
        );
    end

    cdb_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .ack        (ack),
        .result     (result),
        .cdb        (cdb),
        .cdb_valid  (cdb_valid),
        .cdb_result (cdb_result)
    );

    phys_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .cdb       (cdb),
        .ext_wb    (ext_wb),
        .rd1_tag   (rs1_tag),
        .rd2_tag   (rs2_tag),
        .rd1_value (rs1_value),
        .rd2_value (rs2_value)
    );

endmodule

// File: verif/br_cluster_properties.sv
`timescale 1ns/100ps
`include "br_defs.svh"

module br_cluster_properties (
    input logic                        clk,
    input logic                        rst,
    input logic [`BR_NUM_STATIONS-1:0] req,
    input logic [`BR_NUM_STATIONS-1:0] ack,
    input logic                        cdb_valid
);

    ////////////////////////////////////////
    // four-phase handshake
    ////////////////////////////////////////

    // no ack without a request behind it
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        ((ack & ~$past(ack) & ~req) == '0))
        else $error("ack rose while req was low");

    // req drops only after its ack
    req_held: assert property (@(posedge clk) disable iff (rst)
        (($past(req) & ~$past(ack) & ~req) == '0))
        else $error("req fell before ack");

    ////////////////////////////////////////
    // cdb
    ////////////////////////////////////////

    one_grant: assert property (@(posedge clk) disable iff (rst)
        $onehot0(ack & ~$past(ack)))
        else $error("more than one ack rose in a cycle");

    cdb_per_grant: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> |(ack & ~$past(ack)))
        else $error("cdb_valid without a fresh grant");

endmodule

bind cdb_arbiter br_cluster_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .ack       (ack),
    .cdb_valid (cdb_valid)
);

// File: verif/br_cluster_tb.sv
`timescale 1ns/100ps
`include "br_defs.svh"

module br_cluster_tb;

    localparam logic [`BR_PHYS_IDX-1:0] LINK_TAG = (`BR_PHYS_IDX)'(60);

    typedef struct {
        string                   name;
        br_pkg::br_op_e          op;
        logic [`BR_PHYS_IDX-1:0] t1;
        logic [`BR_PHYS_IDX-1:0] t2;
        logic [`BR_XLEN-1:0]     v1;
        logic [`BR_XLEN-1:0]     v2;
        logic [1:0]              late;
        logic [`BR_XLEN-1:0]     pc;
        logic [`BR_XLEN-1:0]     imm;
        logic                    ptk;
        logic [`BR_XLEN-1:0]     ptgt;
        logic [`BR_PHYS_IDX-1:0] rd;
        logic                    hold;
        logic                    from_cdb;
        logic                    taken;
        logic [`BR_XLEN-1:0]     target;
        logic                    misp;
    } row_t;

    logic               clk;
    logic               rst;
    logic               disp_valid;
    br_pkg::br_uop_t    disp_uop;
    logic               disp_ready;
    br_pkg::wb_t        ext_wb;
    logic               cdb_valid;
    br_pkg::br_result_t cdb_result;

    row_t                    rows [$];
    logic [`BR_PHYS_IDX-1:0] late_tag [$];
    logic [`BR_XLEN-1:0]     late_val [$];
    int                      late_rob [$];
    int                      late_left [32];
    logic                    dispatched [32];
    logic                    seen [32];
    logic                    cdb_seen [`BR_PHYS_REGS];
    int                      n_seen;
    int                      cycles;
    int                      limit;
    logic                    saw_full;
    integer                  seed;

    br_cluster UUT (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp_uop   (disp_uop),
        .disp_ready (disp_ready),
        .ext_wb     (ext_wb),
        .cdb_valid  (cdb_valid),
        .cdb_result (cdb_result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic stop_with(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // operand tags follow the row index, 2n+1 and 2n+2
    task automatic add_row(input string name, input br_pkg::br_op_e op,
                           input logic [31:0] v1, input logic [31:0] v2, input logic [1:0] late,
                           input logic [31:0] pc, input logic [31:0] imm, input logic ptk,
                           input logic [31:0] ptgt, input logic hold, input logic taken,
                           input logic [31:0] target, input logic misp);
        row_t r;
        r.name = name;
        r.op = op;
        r.t1 = (`BR_PHYS_IDX)'(2 * rows.size() + 1);
        r.t2 = (`BR_PHYS_IDX)'(2 * rows.size() + 2);
        r.v1 = v1;
        r.v2 = v2;
        r.late = late;
        r.pc = pc;
        r.imm = imm;
        r.ptk = ptk;
        r.ptgt = ptgt;
        r.rd = '0;
        r.hold = hold;
        r.from_cdb = 1'b0;
        r.taken = taken;
        r.target = target;
        r.misp = misp;
        rows.push_back(r);
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    task automatic build_table();
        int k;
        add_row("beq_eq", br_pkg::BEQ, 5, 5, 0, 'h100, 'h20, 1, 'h120, 0, 1, 'h120, 0);
        add_row("beq_ne", br_pkg::BEQ, 5, 6, 0, 'h200, 'h40, 1, 'h240, 0, 0, 'h240, 1);
        add_row("bne_back", br_pkg::BNE, 7, 9, 0, 'h300, 'hffff_fff8, 0, 0, 0, 1, 'h2f8, 1);
        add_row("blt_signed", br_pkg::BLT, 'hffff_ffff, 1, 0, 'h400, 'h10, 1, 'h410, 0,
                1, 'h410, 0);
        add_row("bltu_unsigned", br_pkg::BLTU, 'hffff_ffff, 1, 0, 'h500, 'h10, 0, 0, 0,
                0, 'h510, 0);
        add_row("bge_bad_target", br_pkg::BGE, 1, 'hffff_ffff, 0, 'h600, 'h20, 1, 'h624, 0,
                1, 'h620, 1);
        add_row("bgeu_unsigned", br_pkg::BGEU, 1, 'hffff_ffff, 0, 'h700, 'h20, 1, 'h720, 0,
                0, 'h720, 1);
        add_row("blt_equal", br_pkg::BLT, 3, 3, 0, 'h800, 4, 0, 0, 0, 0, 'h804, 0);
        add_row("bge_equal", br_pkg::BGE, 3, 3, 0, 'h900, 4, 1, 'h904, 0, 1, 'h904, 0);
        // jump whose link value feeds the next row
        add_row("jal_link", br_pkg::JAL, 0, 0, 0, 'ha00, 'h100, 1, 'hb00, 0, 1, 'hb00, 0);
        k = rows.size() - 1;
        rows[k].rd = LINK_TAG;
        add_row("jalr_cdb", br_pkg::JALR, 0, 0, 0, 'hc00, 3, 1, 'ha06, 0, 1, 'ha06, 0);
        k = rows.size() - 1;
        rows[k].t1 = LINK_TAG;
        rows[k].from_cdb = 1'b1;
        add_row("jalr_odd", br_pkg::JALR, 'h1001, 0, 1, 'hd00, 2, 1, 'h1000, 0, 1, 'h1002, 1);
        add_row("bltu_late_both", br_pkg::BLTU, 2, 3, 3, 'he00, 'h40, 1, 'he40, 0, 1, 'he40, 0);
        add_row("bne_late_rs2", br_pkg::BNE, 4, 4, 2, 'hf00, 8, 0, 0, 0, 0, 'hf08, 0);
        // twelve held rows fill every station
        add_row("h0", br_pkg::BEQ, 1, 1, 1, 'h1000, 'h10, 1, 'h1010, 1, 1, 'h1010, 0);
        add_row("h1", br_pkg::BNE, 1, 1, 1, 'h1100, 'h10, 0, 0, 1, 0, 'h1110, 0);
        add_row("h2", br_pkg::BLT, 'h8000_0000, 0, 1, 'h1200, 'h10, 0, 0, 1, 1, 'h1210, 1);
        add_row("h3", br_pkg::BGE, 'h8000_0000, 0, 1, 'h1300, 'h10, 0, 0, 1, 0, 'h1310, 0);
        add_row("h4", br_pkg::BLTU, 0, 'h8000_0000, 1, 'h1400, 'h10, 1, 'h1410, 1, 1, 'h1410, 0);
        add_row("h5", br_pkg::BGEU, 0, 'h8000_0000, 1, 'h1500, 'h10, 0, 0, 1, 0, 'h1510, 0);
        add_row("h6", br_pkg::JAL, 0, 0, 1, 'h1600, 'hffff_fff0, 1, 'h15f0, 1, 1, 'h15f0, 0);
        add_row("h7", br_pkg::JALR, 'h2000, 0, 1, 'h1700, 5, 1, 'h2004, 1, 1, 'h2004, 0);
        add_row("h8", br_pkg::BEQ, 2, 3, 1, 'h1800, 'h10, 1, 'h1810, 1, 0, 'h1810, 1);
        add_row("h9", br_pkg::BNE, 2, 3, 1, 'h1900, 'h10, 1, 'h1914, 1, 1, 'h1910, 1);
        add_row("h10", br_pkg::BLT, 5, 7, 1, 'h1a00, 'h20, 1, 'h1a20, 1, 1, 'h1a20, 0);
        add_row("h11", br_pkg::BGEU, 7, 5, 1, 'h1b00, 'h20, 0, 0, 1, 1, 'h1b20, 1);
        add_row("after_full", br_pkg::BEQ, 0, 0, 0, 'h1c00, 8, 1, 'h1c08, 0, 1, 'h1c08, 0);
    endtask

    ////////////////////////////////////////
    // driving
    ////////////////////////////////////////

    function automatic br_pkg::br_uop_t build_uop(input int i);
        br_pkg::br_uop_t u;
        u.rob_id = (`BR_ROB_IDX)'(i);
        u.op = rows[i].op;
        u.rd_phy = rows[i].rd;
        u.rs1_phy = rows[i].t1;
        u.rs1_ready = !rows[i].late[0] && (!rows[i].from_cdb || cdb_seen[rows[i].t1]);
        u.rs2_phy = rows[i].t2;
        u.rs2_ready = !rows[i].late[1];
        u.pc = rows[i].pc;
        u.imm = rows[i].imm;
        u.predict_taken = rows[i].ptk;
        u.predict_target = rows[i].ptgt;
        return u;
    endfunction

    task automatic write_ext(input logic [`BR_PHYS_IDX-1:0] tag, input logic [31:0] value);
        ext_wb.valid = 1'b1;
        ext_wb.rd_phy = tag;
        ext_wb.value = value;
        tick();
        ext_wb.valid = 1'b0;
    endtask

    task automatic send_late();
        int r;
        r = late_rob.pop_front();
        late_left[r] = late_left[r] - 1;
        write_ext(late_tag.pop_front(), late_val.pop_front());
    endtask

    task automatic flush_late();
        while (late_tag.size() > 0) begin
            repeat ((($random(seed)) & 3) + 1) tick();
            send_late();
        end
    endtask

    task automatic queue_late(input logic [`BR_PHYS_IDX-1:0] tag, input logic [31:0] value,
                              input int r);
        late_tag.push_back(tag);
        late_val.push_back(value);
        late_rob.push_back(r);
        late_left[r] = late_left[r] + 1;
    endtask

    task automatic run_row(input int i);
        if (!rows[i].late[0] && !rows[i].from_cdb) write_ext(rows[i].t1, rows[i].v1);
        if (!rows[i].late[1]) write_ext(rows[i].t2, rows[i].v2);
        if (rows[i].late[0]) queue_late(rows[i].t1, rows[i].v1, i);
        if (rows[i].late[1]) queue_late(rows[i].t2, rows[i].v2, i);
        dispatched[i] = 1'b1;
        disp_valid = 1'b1;
        disp_uop = build_uop(i);
        // stations full, release a held operand to make room
        while (!disp_ready) begin
            saw_full = 1'b1;
            if (late_tag.size() > 0) begin
                send_late();
            end else begin
                tick();
            end
            disp_uop = build_uop(i);
        end
        tick();
        disp_valid = 1'b0;
        if (!rows[i].hold) flush_late();
    endtask

    ////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////

    task automatic score(input br_pkg::br_result_t res);
        int r;
        r = int'(res.rob_id);
        if (r >= rows.size() || !dispatched[r]) stop_with($sformatf("unexpected rob_id %0d", r));
        if (seen[r]) stop_with($sformatf("rob_id %0d left the CDB twice", r));
        if (late_left[r] != 0) stop_with($sformatf("%s resolved before its operand", rows[r].name));
        check_value({rows[r].name, " rd_phy"}, 32'(rows[r].rd), 32'(res.rd_phy));
        check_value({rows[r].name, " link"}, rows[r].pc + 32'd4, res.link_value);
        check_value({rows[r].name, " taken"}, 32'(rows[r].taken), 32'(res.taken));
        check_value({rows[r].name, " target"}, rows[r].target, res.target);
        check_value({rows[r].name, " mispredict"}, 32'(rows[r].misp), 32'(res.mispredict));
        seen[r] = 1'b1;
        n_seen = n_seen + 1;
        if (res.rd_phy != '0) cdb_seen[res.rd_phy] = 1'b1;
    endtask

    always @(negedge clk) begin
        if (!rst && cdb_valid) score(cdb_result);
        if (!rst && UUT.cdb.valid && ext_wb.valid && UUT.cdb.rd_phy != '0 &&
            UUT.cdb.rd_phy == ext_wb.rd_phy) begin
            stop_with("CDB and external write-back hit the same register in one cycle");
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            stop_with($sformatf("timeout, %0d of %0d results seen", n_seen, rows.size()));
        end
    end

    initial begin
        seed = 32'h529f_be34;
        rst = 1'b1;
        disp_valid = 1'b0;
        disp_uop = '0;
        ext_wb = '0;
        n_seen = 0;
        cycles = 0;
        limit = 0;
        saw_full = 1'b0;
        for (int i = 0; i < 32; i++) begin
            late_left[i] = 0;
            dispatched[i] = 1'b0;
            seen[i] = 1'b0;
        end
        for (int i = 0; i < `BR_PHYS_REGS; i++) cdb_seen[i] = 1'b0;
        build_table();
        limit = 40 * rows.size() + 100;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) run_row(i);
        flush_late();
        wait (n_seen == rows.size());
        repeat (10) tick();
        if (!saw_full) begin
            stop_with("disp_ready never fell during the burst");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// File: br_cluster.f
+incdir+common
common/br_pkg.sv
logic/br_unit.sv
rs/rs_station.sv
logic/br_dispatch.sv
logic/cdb_arbiter.sv
logic/phys_regfile.sv
logic/br_cluster.sv
verif/br_cluster_properties.sv
verif/br_cluster_tb.sv

// File: Makefile
TOP = br_cluster_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f br_cluster.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
